//--- include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN       32
`define RV_ILEN       32
`define RV_REG_IDX_W  5
`define RV_RESET_PC   32'h0000_0000

// alu operation codes
`define RV_ALU_OP_W   4
`define RV_ALU_ADD    4'd0
`define RV_ALU_SUB    4'd1
`define RV_ALU_AND    4'd2
`define RV_ALU_OR     4'd3
`define RV_ALU_XOR    4'd4
`define RV_ALU_SLT    4'd5
`define RV_ALU_PASS_B 4'd6

// operand source for the execute stage
`define RV_FWD_SEL_W  2
`define RV_FWD_RF     2'd0
`define RV_FWD_LS     2'd1
`define RV_FWD_WB     2'd2

`define RV_OP_REG     7'b0110011
`define RV_OP_IMM     7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111

`endif

//--- hw/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

  // data word and pc
  typedef logic [`RV_XLEN-1:0] xlen_t;

  typedef logic [`RV_ILEN-1:0] instr_t;

  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // see RV_ALU_* codes
  typedef logic [`RV_ALU_OP_W-1:0] alu_op_t;

  // rf value, ls stage or wb stage
  typedef logic [`RV_FWD_SEL_W-1:0] fwd_sel_t;

endpackage

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module fetch_stage (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           imem_valid_i,
  input  rv_pkg::instr_t imem_rdata_i,
  input  logic           redirect_i,
  input  rv_pkg::xlen_t  redirect_pc_i,
  output rv_pkg::xlen_t  imem_addr_o,
  output logic           if_valid_o,
  output rv_pkg::xlen_t  if_pc_o,
  output rv_pkg::instr_t if_instr_o
);
  import rv_pkg::*;

  xlen_t pc_q;
  xlen_t pc_d;

  // redirect wins over a missing instruction
  always_comb begin
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (imem_valid_i) begin
      pc_d = pc_q + xlen_t'(4);
    end else begin
      pc_d = pc_q; // hold until memory answers
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q       <= `RV_RESET_PC;
      if_valid_o <= 1'b0;
    end else begin
      pc_q       <= pc_d;
      if_valid_o <= imem_valid_i & ~redirect_i; // bubble on stall or flush
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if_pc_o    <= pc_q;
    if_instr_o <= imem_rdata_i;
  end

  assign imem_addr_o = pc_q;

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module decode_stage (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             if_valid_i,
  input  rv_pkg::xlen_t    if_pc_i,
  input  rv_pkg::instr_t   if_instr_i,
  input  logic             flush_i,
  input  logic             rf_wen_i,
  input  rv_pkg::reg_idx_t rf_waddr_i,
  input  rv_pkg::xlen_t    rf_wdata_i,
  output logic             id_valid_o,
  output rv_pkg::xlen_t    id_pc_o,
  output rv_pkg::instr_t   id_instr_o,
  output rv_pkg::xlen_t    id_rs1_o,
  output rv_pkg::xlen_t    id_rs2_o,
  output rv_pkg::xlen_t    id_imm_o,
  output rv_pkg::reg_idx_t id_rs1_idx_o,
  output rv_pkg::reg_idx_t id_rs2_idx_o,
  output rv_pkg::reg_idx_t id_rd_o,
  output rv_pkg::alu_op_t  id_alu_op_o,
  output logic             id_use_imm_o,
  output logic             id_wen_o,
  output logic             id_is_brc_o,
  output logic             id_is_jal_o,
  output rv_pkg::xlen_t    reg_a0_o
);
  import rv_pkg::*;

  xlen_t    rf_q [1:31]; // x0 is not stored
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  xlen_t    dec_imm;
  alu_op_t  dec_alu_op;
  logic     dec_use_imm;
  logic     dec_wen;
  logic     dec_is_brc;
  logic     dec_is_jal;
  logic [2:0] funct3;

  // read port, sees a write made in the same cycle
  function automatic xlen_t rf_read(reg_idx_t idx);
    if (idx == '0) begin
      rf_read = '0;
    end else if (rf_wen_i && rf_waddr_i == idx) begin
      rf_read = rf_wdata_i;
    end else begin
      rf_read = rf_q[idx];
    end
  endfunction

  always_ff @(posedge clk) begin
    if (rf_wen_i && rf_waddr_i != '0) begin
      rf_q[rf_waddr_i] <= rf_wdata_i;
    end
  end

  assign rs1_idx = if_instr_i[19:15];
  assign rs2_idx = if_instr_i[24:20];
  assign funct3  = if_instr_i[14:12];

  // anything outside the subset leaves the defaults, a no-op
  always_comb begin
    dec_imm     = '0;
    dec_alu_op  = `RV_ALU_ADD;
    dec_use_imm = 1'b0;
    dec_wen     = 1'b0;
    dec_is_brc  = 1'b0;
    dec_is_jal  = 1'b0;
    case (if_instr_i[6:0])
      `RV_OP_REG: begin
        dec_wen = 1'b1;
        case (funct3)
          3'b000:  dec_alu_op = if_instr_i[30] ? `RV_ALU_SUB : `RV_ALU_ADD;
          3'b010:  dec_alu_op = `RV_ALU_SLT;
          3'b100:  dec_alu_op = `RV_ALU_XOR;
          3'b110:  dec_alu_op = `RV_ALU_OR;
          3'b111:  dec_alu_op = `RV_ALU_AND;
          default: dec_wen = 1'b0;
        endcase
      end
      `RV_OP_IMM: begin
        dec_wen     = 1'b1;
        dec_use_imm = 1'b1;
        dec_imm     = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
        case (funct3)
          3'b000:  dec_alu_op = `RV_ALU_ADD;
          3'b100:  dec_alu_op = `RV_ALU_XOR;
          3'b110:  dec_alu_op = `RV_ALU_OR;
          3'b111:  dec_alu_op = `RV_ALU_AND;
          default: dec_wen = 1'b0; // slti, shifts not supported
        endcase
      end
      `RV_OP_LUI: begin
        dec_wen     = 1'b1;
        dec_use_imm = 1'b1;
        dec_alu_op  = `RV_ALU_PASS_B;
        dec_imm     = {if_instr_i[31:12], 12'b0};
      end
      `RV_OP_BRANCH: begin
        dec_is_brc = (funct3 == 3'b000) || (funct3 == 3'b001); // beq, bne
        dec_imm    = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                      if_instr_i[30:25], if_instr_i[11:8], 1'b0};
      end
      `RV_OP_JAL: begin
        dec_is_jal = 1'b1;
        dec_wen    = 1'b1; // link value comes from execute
        dec_imm    = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                      if_instr_i[20], if_instr_i[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_valid_o <= 1'b0;
    end else begin
      id_valid_o <= if_valid_i & ~flush_i;
    end
  end

  // ID/EX payload, qualified by id_valid_o downstream
  always_ff @(posedge clk) begin
    id_pc_o      <= if_pc_i;
    id_instr_o   <= if_instr_i;
    id_rs1_o     <= rf_read(rs1_idx);
    id_rs2_o     <= rf_read(rs2_idx);
    id_imm_o     <= dec_imm;
    id_rs1_idx_o <= rs1_idx;
    id_rs2_idx_o <= rs2_idx;
    id_rd_o      <= if_instr_i[11:7];
    id_alu_op_o  <= dec_alu_op;
    id_use_imm_o <= dec_use_imm;
    id_wen_o     <= dec_wen;
    id_is_brc_o  <= dec_is_brc;
    id_is_jal_o  <= dec_is_jal;
  end

  assign reg_a0_o = rf_q[10];

endmodule

//--- hw/forwarding_unit.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module forwarding_unit (
  input  rv_pkg::reg_idx_t ex_rs1_idx_i,
  input  rv_pkg::reg_idx_t ex_rs2_idx_i,
  input  logic             ls_valid_i,
  input  logic             ls_wen_i,
  input  rv_pkg::reg_idx_t ls_rd_i,
  input  rv_pkg::xlen_t    ls_data_i,
  input  logic             wb_valid_i,
  input  logic             wb_wen_i,
  input  rv_pkg::reg_idx_t wb_rd_i,
  input  rv_pkg::xlen_t    wb_data_i,
  output rv_pkg::fwd_sel_t rs1_sel_o,
  output rv_pkg::fwd_sel_t rs2_sel_o,
  output rv_pkg::xlen_t    fwd_ls_o,
  output rv_pkg::xlen_t    fwd_wb_o
);
  import rv_pkg::*;

  logic ls_hit_ok;
  logic wb_hit_ok;

  // a stage can only supply a value it is about to write
  assign ls_hit_ok = ls_valid_i & ls_wen_i & (ls_rd_i != '0);
  assign wb_hit_ok = wb_valid_i & wb_wen_i & (wb_rd_i != '0);

  // youngest producer first
  function automatic fwd_sel_t select(reg_idx_t idx);
    if (idx == '0) begin
      select = `RV_FWD_RF;
    end else if (ls_hit_ok && ls_rd_i == idx) begin
      select = `RV_FWD_LS;
    end else if (wb_hit_ok && wb_rd_i == idx) begin
      select = `RV_FWD_WB;
    end else begin
      select = `RV_FWD_RF;
    end
  endfunction

  assign rs1_sel_o = select(ex_rs1_idx_i);
  assign rs2_sel_o = select(ex_rs2_idx_i);

  assign fwd_ls_o = ls_data_i;
  assign fwd_wb_o = wb_data_i;

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module execute_stage (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             id_valid_i,
  input  rv_pkg::xlen_t    id_pc_i,
  input  rv_pkg::instr_t   id_instr_i,
  input  rv_pkg::xlen_t    id_rs1_i,
  input  rv_pkg::xlen_t    id_rs2_i,
  input  rv_pkg::xlen_t    id_imm_i,
  input  rv_pkg::reg_idx_t id_rd_i,
  input  rv_pkg::alu_op_t  id_alu_op_i,
  input  logic             id_use_imm_i,
  input  logic             id_wen_i,
  input  logic             id_is_brc_i,
  input  logic             id_is_jal_i,
  input  rv_pkg::fwd_sel_t rs1_sel_i,
  input  rv_pkg::fwd_sel_t rs2_sel_i,
  input  rv_pkg::xlen_t    fwd_ls_i,
  input  rv_pkg::xlen_t    fwd_wb_i,
  output logic             redirect_o,
  output rv_pkg::xlen_t    redirect_pc_o,
  output logic             ls_valid_o,
  output logic             ls_wen_o,
  output rv_pkg::reg_idx_t ls_rd_o,
  output rv_pkg::xlen_t    ls_pc_o,
  output rv_pkg::instr_t   ls_instr_o,
  output rv_pkg::xlen_t    ls_data_o
);
  import rv_pkg::*;

  xlen_t op_a;
  xlen_t op_b_reg;
  xlen_t op_b;
  xlen_t alu_res;
  xlen_t ex_res;
  logic  brc_taken;

  function automatic xlen_t pick(fwd_sel_t sel, xlen_t rf_val);
    case (sel)
      `RV_FWD_LS: pick = fwd_ls_i;
      `RV_FWD_WB: pick = fwd_wb_i;
      default:    pick = rf_val;
    endcase
  endfunction

  assign op_a     = pick(rs1_sel_i, id_rs1_i);
  assign op_b_reg = pick(rs2_sel_i, id_rs2_i);
  assign op_b     = id_use_imm_i ? id_imm_i : op_b_reg;

  always_comb begin
    case (id_alu_op_i)
      `RV_ALU_ADD:    alu_res = op_a + op_b;
      `RV_ALU_SUB:    alu_res = op_a - op_b;
      `RV_ALU_AND:    alu_res = op_a & op_b;
      `RV_ALU_OR:     alu_res = op_a | op_b;
      `RV_ALU_XOR:    alu_res = op_a ^ op_b;
      `RV_ALU_SLT:    alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      `RV_ALU_PASS_B: alu_res = op_b; // lui
      default:        alu_res = '0;
    endcase
  end

  assign ex_res = id_is_jal_i ? id_pc_i + xlen_t'(4) : alu_res; // link address

  // funct3 bit 0 tells bne from beq
  assign brc_taken = id_is_brc_i & ((op_a == op_b_reg) ^ id_instr_i[12]);

  assign redirect_o    = id_valid_i & (brc_taken | id_is_jal_i);
  assign redirect_pc_o = id_pc_i + id_imm_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ls_valid_o <= 1'b0;
      ls_wen_o   <= 1'b0;
    end else begin
      ls_valid_o <= id_valid_i;
      ls_wen_o   <= id_valid_i & id_wen_i;
    end
  end

  // EX/LS payload
  always_ff @(posedge clk) begin
    ls_rd_o    <= id_rd_i;
    ls_pc_o    <= id_pc_i;
    ls_instr_o <= id_instr_i;
    ls_data_o  <= ex_res;
  end

endmodule

//--- hw/writeback_stage.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module writeback_stage (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             ls_valid_i,
  input  logic             ls_wen_i,
  input  rv_pkg::reg_idx_t ls_rd_i,
  input  rv_pkg::xlen_t    ls_pc_i,
  input  rv_pkg::instr_t   ls_instr_i,
  input  rv_pkg::xlen_t    ls_data_i,
  output logic             wb_valid_o,
  output logic             wb_wen_o,
  output rv_pkg::reg_idx_t wb_rd_o,
  output rv_pkg::xlen_t    wb_data_o,
  output rv_pkg::xlen_t    retire_pc_o,
  output rv_pkg::instr_t   retire_instr_o
);
  import rv_pkg::*;

  logic wen_d;

  // x0 never gets written
  assign wen_d = ls_valid_i & ls_wen_i & (ls_rd_i != '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
      wb_wen_o   <= 1'b0;
    end else begin
      wb_valid_o <= ls_valid_i; // retire strobe
      wb_wen_o   <= wen_d;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o        <= ls_rd_i;
    wb_data_o      <= ls_data_i;
    retire_pc_o    <= ls_pc_i;
    retire_instr_o <= ls_instr_i;
  end

endmodule

//--- hw/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
  input  logic             clk,
  input  logic             rst_n_i,
  output rv_pkg::xlen_t    imem_addr_o,
  input  rv_pkg::instr_t   imem_rdata_i,
  input  logic             imem_valid_i,
  output logic             retire_valid_o,
  output rv_pkg::xlen_t    retire_pc_o,
  output rv_pkg::instr_t   retire_instr_o,
  output logic             retire_wen_o,
  output rv_pkg::reg_idx_t retire_rd_o,
  output rv_pkg::xlen_t    retire_data_o,
  output rv_pkg::xlen_t    reg_a0_o
);
  import rv_pkg::*;

  logic     redirect;
  xlen_t    redirect_pc;
  logic     if_valid;
  xlen_t    if_pc;
  instr_t   if_instr;

  logic     id_valid, id_use_imm, id_wen, id_is_brc, id_is_jal;
  xlen_t    id_pc, id_rs1, id_rs2, id_imm;
  instr_t   id_instr;
  reg_idx_t id_rs1_idx, id_rs2_idx, id_rd;
  alu_op_t  id_alu_op;

  fwd_sel_t rs1_sel, rs2_sel;
  xlen_t    fwd_ls, fwd_wb;

  logic     ls_valid, ls_wen;
  reg_idx_t ls_rd;
  xlen_t    ls_pc, ls_data;
  instr_t   ls_instr;

  logic     wb_valid, wb_wen;
  reg_idx_t wb_rd;
  xlen_t    wb_data;

  fetch_stage u_fetch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .imem_valid_i  (imem_valid_i),
    .imem_rdata_i  (imem_rdata_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_addr_o   (imem_addr_o),
    .if_valid_o    (if_valid),
    .if_pc_o       (if_pc),
    .if_instr_o    (if_instr)
  );

  decode_stage u_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .if_valid_i   (if_valid),
    .if_pc_i      (if_pc),
    .if_instr_i   (if_instr),
    .flush_i      (redirect), // taken branch or jal in EX
    .rf_wen_i     (wb_wen),
    .rf_waddr_i   (wb_rd),
    .rf_wdata_i   (wb_data),
    .id_valid_o   (id_valid),
    .id_pc_o      (id_pc),
    .id_instr_o   (id_instr),
    .id_rs1_o     (id_rs1),
    .id_rs2_o     (id_rs2),
    .id_imm_o     (id_imm),
    .id_rs1_idx_o (id_rs1_idx),
    .id_rs2_idx_o (id_rs2_idx),
    .id_rd_o      (id_rd),
    .id_alu_op_o  (id_alu_op),
    .id_use_imm_o (id_use_imm),
    .id_wen_o     (id_wen),
    .id_is_brc_o  (id_is_brc),
    .id_is_jal_o  (id_is_jal),
    .reg_a0_o     (reg_a0_o)
  );

  forwarding_unit u_fwd (
    .ex_rs1_idx_i (id_rs1_idx),
    .ex_rs2_idx_i (id_rs2_idx),
    .ls_valid_i   (ls_valid),
    .ls_wen_i     (ls_wen),
    .ls_rd_i      (ls_rd),
    .ls_data_i    (ls_data),
    .wb_valid_i   (wb_valid),
    .wb_wen_i     (wb_wen),
    .wb_rd_i      (wb_rd),
    .wb_data_i    (wb_data),
    .rs1_sel_o    (rs1_sel),
    .rs2_sel_o    (rs2_sel),
    .fwd_ls_o     (fwd_ls),
    .fwd_wb_o     (fwd_wb)
  );

  execute_stage u_execute (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .id_valid_i    (id_valid),
    .id_pc_i       (id_pc),
    .id_instr_i    (id_instr),
    .id_rs1_i      (id_rs1),
    .id_rs2_i      (id_rs2),
    .id_imm_i      (id_imm),
    .id_rd_i       (id_rd),
    .id_alu_op_i   (id_alu_op),
    .id_use_imm_i  (id_use_imm),
    .id_wen_i      (id_wen),
    .id_is_brc_i   (id_is_brc),
    .id_is_jal_i   (id_is_jal),
    .rs1_sel_i     (rs1_sel),
    .rs2_sel_i     (rs2_sel),
    .fwd_ls_i      (fwd_ls),
    .fwd_wb_i      (fwd_wb),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .ls_valid_o    (ls_valid),
    .ls_wen_o      (ls_wen),
    .ls_rd_o       (ls_rd),
    .ls_pc_o       (ls_pc),
    .ls_instr_o    (ls_instr),
    .ls_data_o     (ls_data)
  );

  writeback_stage u_writeback (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ls_valid_i     (ls_valid),
    .ls_wen_i       (ls_wen),
    .ls_rd_i        (ls_rd),
    .ls_pc_i        (ls_pc),
    .ls_instr_i     (ls_instr),
    .ls_data_i      (ls_data),
    .wb_valid_o     (wb_valid),
    .wb_wen_o       (wb_wen),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .retire_pc_o    (retire_pc_o),
    .retire_instr_o (retire_instr_o)
  );

  // debug view for the simulator
  assign retire_valid_o = wb_valid;
  assign retire_wen_o   = wb_wen;
  assign retire_rd_o    = wb_rd;
  assign retire_data_o  = wb_data;

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset low for a fixed number of rising edges, released on an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core_tb;
  import rv_pkg::*;

  localparam int    PROG_LEN       = 150;
  localparam int    IMEM_WORDS     = 256;
  localparam int    A0_LUI_IDX     = PROG_LEN - 4;
  localparam int    LAST_CTRL_IDX  = A0_LUI_IDX - 4; // furthest target still lands before the a0 pair
  localparam int    TIMEOUT_CYCLES = 10 * PROG_LEN + 100;
  localparam xlen_t LOOP_PC        = xlen_t'((PROG_LEN - 1) * 4);
  localparam logic [31:0] SEED     = 32'haddd_0b1d;

  logic     clk;
  logic     rst_n;
  xlen_t    imem_addr;
  instr_t   imem_rdata;
  logic     imem_valid = 1'b0;
  logic     retire_valid;
  xlen_t    retire_pc;
  instr_t   retire_instr;
  logic     retire_wen;
  reg_idx_t retire_rd;
  xlen_t    retire_data;
  xlen_t    reg_a0;

  instr_t      imem [0:IMEM_WORDS-1];
  logic        valid_pattern [0:TIMEOUT_CYCLES];
  logic [31:0] rng_state;
  xlen_t       model_regs [0:31] = '{default: '0};
  xlen_t       model_pc = `RV_RESET_PC;
  int          cycle_count = 0;
  int          retired = 0;

  xlen_t    exp_pc;
  instr_t   exp_instr;
  reg_idx_t exp_rd;
  logic     exp_wen;
  xlen_t    exp_data;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rv_core_top dut_i (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .imem_addr_o    (imem_addr),
    .imem_rdata_i   (imem_rdata),
    .imem_valid_i   (imem_valid),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_instr_o (retire_instr),
    .retire_wen_o   (retire_wen),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data),
    .reg_a0_o       (reg_a0)
  );

  assign imem_rdata = imem[imem_addr[9:2]]; // 256 words, wraps

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic instr_t pack_reg_op(logic [2:0] sel, reg_idx_t rs2, reg_idx_t rs1,
                                         reg_idx_t rd);
    logic [2:0] f3;
    logic [6:0] f7;
    case (sel)
      3'd2:    f3 = 3'b111; // and
      3'd3:    f3 = 3'b110; // or
      3'd4:    f3 = 3'b100; // xor
      3'd5:    f3 = 3'b010; // slt
      default: f3 = 3'b000; // add, sub when sel is odd
    endcase
    f7 = (f3 == 3'b000 && sel[0]) ? 7'b0100000 : 7'b0000000;
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic instr_t pack_imm_op(logic [1:0] sel, logic [11:0] imm, reg_idx_t rs1,
                                         reg_idx_t rd);
    logic [2:0] f3;
    case (sel)
      2'd1:    f3 = 3'b111;
      2'd2:    f3 = 3'b110;
      2'd3:    f3 = 3'b100;
      default: f3 = 3'b000; // addi
    endcase
    return {imm, rs1, f3, rd, `RV_OP_IMM};
  endfunction

  function automatic instr_t pack_lui(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, `RV_OP_LUI};
  endfunction

  function automatic instr_t pack_branch(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                         logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  function automatic instr_t pack_jal(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
  endfunction

  // x1..x7 get written first since the register file has no reset
  function automatic instr_t random_instr(int idx);
    logic [31:0] r;
    logic [31:0] s;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [12:0] off;
    logic [3:0]  kind;
    instr_t      w;
    r    = next_random();
    s    = next_random();
    rd   = {2'b00, r[2:0]};
    rs1  = {2'b00, r[5:3]};
    rs2  = {2'b00, r[8:6]};
    off  = r[9] ? 13'd12 : 13'd8;
    kind = r[31:28];
    if (idx > LAST_CTRL_IDX && kind >= 4'd12) begin
      kind = kind - 4'd12; // straight-line tail
    end
    if (idx == PROG_LEN - 1) begin
      w = pack_jal(21'd0, 5'd0); // final self-loop
    end else if (idx < 7) begin
      w = pack_imm_op(2'd0, s[31:20], 5'd0, reg_idx_t'(idx + 1));
    end else if (idx == A0_LUI_IDX) begin
      w = pack_lui(s[19:0], 5'd10);
    end else if (idx == A0_LUI_IDX + 1) begin
      w = pack_imm_op(2'd0, s[31:20], 5'd10, 5'd10);
    end else begin
      case (kind)
        4'd5, 4'd6, 4'd7, 4'd8: w = pack_imm_op(r[11:10], s[31:20], rs1, rd);
        4'd9, 4'd10:            w = pack_lui(s[19:0], rd);
        4'd12, 4'd13:           w = pack_branch(off, r[12] ? rs1 : rs2, rs1, 3'b000);
        4'd14:                  w = pack_branch(off, rs2, rs1, 3'b001);
        4'd15:                  w = pack_jal({8'd0, off}, rd);
        default:                w = pack_reg_op(r[14:12], rs2, rs1, rd);
      endcase
    end
    return w;
  endfunction

  // one architectural step of the ISA subset
  function automatic void model_step(output xlen_t pc, output instr_t instr,
                                     output reg_idx_t rd, output logic wen, output xlen_t data);
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_i;
    xlen_t      next_pc;
    logic [2:0] f3;
    pc      = model_pc;
    instr   = imem[model_pc[9:2]];
    rd      = instr[11:7];
    f3      = instr[14:12];
    a       = model_regs[instr[19:15]];
    b       = model_regs[instr[24:20]];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    next_pc = model_pc + 32'd4;
    wen     = 1'b0;
    data    = '0;
    case (instr[6:0])
      `RV_OP_REG: begin
        wen = 1'b1;
        case (f3)
          3'b000:  data = instr[30] ? a - b : a + b;
          3'b010:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b100:  data = a ^ b;
          3'b110:  data = a | b;
          3'b111:  data = a & b;
          default: wen = 1'b0;
        endcase
      end
      `RV_OP_IMM: begin
        wen = 1'b1;
        case (f3)
          3'b000:  data = a + imm_i;
          3'b100:  data = a ^ imm_i;
          3'b110:  data = a | imm_i;
          3'b111:  data = a & imm_i;
          default: wen = 1'b0;
        endcase
      end
      `RV_OP_LUI: begin
        wen  = 1'b1;
        data = {instr[31:12], 12'h000};
      end
      `RV_OP_BRANCH: begin
        if ((f3 == 3'b000) ? (a == b) : (a != b)) begin
          next_pc = model_pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        end
      end
      `RV_OP_JAL: begin
        wen     = 1'b1;
        data    = model_pc + 32'd4;
        next_pc = model_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: ;
    endcase
    if (rd == '0) begin
      wen = 1'b0; // x0 stays zero
    end
    if (wen) begin
      model_regs[rd] = data;
    end
    model_pc = next_pc;
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_pc(xlen_t act, xlen_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("MISMATCH at time %0t: retire_pc_o is %h, expected %h",
                              $time, act, exp));
    end
  endtask

  task automatic check_instr(instr_t act, instr_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("MISMATCH at time %0t: retire_instr_o is %h, expected %h",
                              $time, act, exp));
    end
  endtask

  task automatic check_wen(logic act, logic exp);
    if (act !== exp) begin
      stop_on_error($sformatf("MISMATCH at time %0t: retire_wen_o is %b, expected %b",
                              $time, act, exp));
    end
  endtask

  task automatic check_rd(reg_idx_t act, reg_idx_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("MISMATCH at time %0t: retire_rd_o is %0d, expected %0d",
                              $time, act, exp));
    end
  endtask

  task automatic check_data(string name, xlen_t act, xlen_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
                              $time, name, act, exp));
    end
  endtask

  initial begin : build_program
    xlen_t addr;
    rng_state = SEED;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      addr    = xlen_t'(i) << 2;
      imem[i] = addr ^ (addr << 7); // low bits 00, decodes as a no-op
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      imem[i] = random_instr(i);
    end
    for (int i = 0; i <= TIMEOUT_CYCLES; i++) begin
      valid_pattern[i] = (next_random() % 32'd4) != 32'd0; // low about a quarter of the time
    end
  end

  always @(posedge clk) begin
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("timeout: the final loop did not retire within %0d cycles",
                              TIMEOUT_CYCLES));
    end else begin
      cycle_count <= cycle_count + 1;
      imem_valid  <= rst_n & valid_pattern[cycle_count];
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      if (retire_valid !== 1'b0) begin
        stop_on_error("retire_valid_o was not low while reset was asserted");
      end
    end else if (retire_valid === 1'b1) begin
      model_step(exp_pc, exp_instr, exp_rd, exp_wen, exp_data);
      check_pc(retire_pc, exp_pc);
      check_instr(retire_instr, exp_instr);
      check_wen(retire_wen, exp_wen);
      if (exp_wen) begin
        check_rd(retire_rd, exp_rd);
        check_data("retire_data_o", retire_data, exp_data);
      end
      retired = retired + 1;
      if (exp_pc == LOOP_PC) begin
        check_data("reg_a0_o", reg_a0, model_regs[10]);
        $display("retired %0d instructions in %0d cycles", retired, cycle_count);
        $display("ALL TESTS PASSED");
        $finish;
      end
    end else if (retire_valid !== 1'b0) begin
      stop_on_error("retire_valid_o is unknown after reset");
    end
  end

endmodule

//--- project.f
+incdir+include
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/forwarding_unit.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/rv_core_top.sv
sim/tb_clock_gen.sv
sim/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status is the simulator's, non-zero when the run fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module rv_core_tb -f project.f -o rv_core_sim

./obj_dir/rv_core_sim
